// File: Makefile
# Verilator build and run of the camera config testbench

VERILATOR ?= verilator
TOP       ?= tb_cam_cfg
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Test passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/sccb_monitor.sv
// ################################################
// SCCB bus checker, decodes write frames at the pins
// compares them with the register table and counts errors
// ################################################
`timescale 1ns/1ps

module sccb_monitor #(
    parameter int DIV_BITS   = 4,
    parameter int DELAY_UNIT = 64
) (
    input  logic clk,
    input  logic reset,
    input  logic sioc,
    input  logic siod_line, // resolved bus level
    input  logic siod_oe,
    input  logic done,
    output int   errors,
    output int   frames,    // frames finished in this pass
    output int   starts,
    output int   writes_per_pass
);

    import cam_cfg_pkg::*;

    localparam int PERIOD     = 2 ** DIV_BITS;
    localparam int FRAME_CLKS = 32 * PERIOD;

    logic        prev_sioc;
    logic        prev_line;
    logic        prev_done;
    logic        in_frame;
    logic [26:0] bits;     // first bit ends up at the top
    int          bit_cnt;
    int          clk_cnt;  // clocks since reset released
    int          stop_time;

    function automatic logic is_write(input cam_entry_t e);
        return (e.addr != ADDR_DELAY) && (e.addr != ADDR_END);
    endfunction

    // n-th register write of the table as {id, addr, value}
    function automatic logic [23:0] expected_write(input int n);
        int          k;
        int          i;
        logic [23:0] result;
        k = 0;
        result = '0;
        for (i = 0; i < CAM_TABLE_LEN; i++) begin
            if (is_write(CAM_REG_TABLE[i])) begin
                if (k == n) begin
                    result = {CAM_ID_WRITE, CAM_REG_TABLE[i].addr, CAM_REG_TABLE[i].value};
                end
                k++;
            end
        end
        return result;
    endfunction

    function automatic int count_writes();
        int k;
        int i;
        k = 0;
        for (i = 0; i < CAM_TABLE_LEN; i++) begin
            if (is_write(CAM_REG_TABLE[i])) begin
                k++;
            end
        end
        return k;
    endfunction

    // delay units sitting between write n-1 and write n
    function automatic int delay_units_before(input int n);
        int k;
        int i;
        int units;
        k = 0;
        units = 0;
        for (i = 0; i < CAM_TABLE_LEN; i++) begin
            if (CAM_REG_TABLE[i].addr == ADDR_DELAY) begin
                if (k == n) begin
                    units += int'(CAM_REG_TABLE[i].value);
                end
            end else if (is_write(CAM_REG_TABLE[i])) begin
                k++;
            end
        end
        return units;
    endfunction

    assign writes_per_pass = count_writes();

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        if (got !== exp) begin
            $display("Mismatch frame %0d %s: got 0x%h, expected 0x%h", frames, name, got, exp);
            errors++;
        end
    endtask

    task automatic start_frame();
        int units;
        units = delay_units_before(frames);
        // pause plus the one period before siod falls
        if (starts == 0 && clk_cnt < 2 * PERIOD) begin
            $display("start condition %0d clocks after reset, inside the power-up pause",
                     clk_cnt);
            errors++;
        end
        if (in_frame) begin
            $display("start condition in the middle of frame %0d", frames);
            errors++;
        end
        if (frames >= writes_per_pass) begin
            $display("start condition after the last table write at %0t", $time);
            errors++;
        end
        if (frames > 0 && units > 0 &&
            clk_cnt - stop_time < units * DELAY_UNIT - FRAME_CLKS) begin
            $display("bus gap after the delay entry is only %0d clocks", clk_cnt - stop_time);
            errors++;
        end
        starts++;
        in_frame = 1'b1;
        bit_cnt  = 0;
    endtask

    task automatic take_bit();
        int   slot;
        logic exp_oe;
        slot   = bit_cnt + 1;
        exp_oe = !(slot == 9 || slot == 18 || slot == 27); // ack slots released
        if (bit_cnt < 27) begin
            if (siod_oe !== exp_oe) begin
                $display("Mismatch frame %0d siod_oe at bit %0d: got 0x%h, expected 0x%h",
                         frames, slot, siod_oe, exp_oe);
                errors++;
            end
            bits    = {bits[25:0], siod_line};
            bit_cnt = slot;
        end
    endtask

    task automatic end_frame();
        logic [23:0] exp;
        exp = expected_write(frames);
        if (bit_cnt != 27) begin
            $display("frame %0d ended after %0d bits instead of 27", frames, bit_cnt);
            errors++;
        end else if (frames < writes_per_pass) begin
            compare_byte("sccb_id", bits[26:19], exp[23:16]);
            compare_byte("reg_addr", bits[17:10], exp[15:8]);
            compare_byte("value", bits[8:1], exp[7:0]);
        end
        frames++;
        in_frame  = 1'b0;
        stop_time = clk_cnt;
    endtask

    // sampled mid-cycle, away from the DUT's clock edge
    always @(negedge clk) begin
        if (reset) begin
            if (sioc !== 1'b1 || siod_line !== 1'b1 || done !== 1'b0) begin
                $display("bus not idle or done set while reset is held at %0t", $time);
                errors++;
            end
            clk_cnt  = 0;
            in_frame = 1'b0;
            bit_cnt  = 0;
            frames   = 0;
        end else begin
            clk_cnt++;
            if (prev_sioc && sioc && prev_line && !siod_line) begin
                start_frame();
            end else if (prev_sioc && sioc && !prev_line && siod_line && in_frame) begin
                end_frame();
            end else if (!prev_sioc && sioc && in_frame) begin
                take_bit();
            end
            if (done && !prev_done && frames < writes_per_pass - 1) begin
                $display("done raised after only %0d frames", frames);
                errors++;
            end
            if (!done && prev_done) begin
                frames = 0; // restart begins a new pass
            end
        end
        prev_sioc = sioc;
        prev_line = siod_line;
        prev_done = done;
    end

endmodule

// File: bench/tb_cam_cfg.sv
// ################################################
// testbench for the camera config top, two table passes
// pulled-up SCCB line, restart at a random time
// ################################################
`timescale 1ns/1ps

module tb_cam_cfg;

    import cam_cfg_pkg::*;

    localparam int DIV_BITS   = 4;
    localparam int DELAY_UNIT = 64;
    localparam int PERIOD     = 2 ** DIV_BITS;
    localparam int FRAME_CLKS = 32 * PERIOD;
    localparam int PASS_LIMIT = (CAM_TABLE_LEN + 4) * FRAME_CLKS + 256 * DELAY_UNIT;

    logic   clk = 1'b0;
    logic   reset;
    logic   restart;
    logic   done;
    logic   sioc;
    logic   siod_out;
    logic   siod_oe;
    logic   siod_line;
    integer seed;
    int     errors_tb;
    int     tests_run;
    int     tests_failed;
    int     mon_errors;
    int     mon_frames;
    int     mon_starts;
    int     mon_writes;

    assign siod_line = siod_oe ? siod_out : 1'b1; // pull-up when released

    cam_cfg_top #(
        .DIV_BITS   (DIV_BITS),
        .DELAY_UNIT (DELAY_UNIT)
    ) i_dut (
        .clk      (clk),
        .reset    (reset),
        .restart  (restart),
        .done     (done),
        .sioc     (sioc),
        .siod_out (siod_out),
        .siod_oe  (siod_oe)
    );

    sccb_monitor #(
        .DIV_BITS   (DIV_BITS),
        .DELAY_UNIT (DELAY_UNIT)
    ) i_mon (
        .clk             (clk),
        .reset           (reset),
        .sioc            (sioc),
        .siod_line       (siod_line),
        .siod_oe         (siod_oe),
        .done            (done),
        .errors          (mon_errors),
        .frames          (mon_frames),
        .starts          (mon_starts),
        .writes_per_pass (mon_writes)
    );

    always #4 clk = ~clk;

    function automatic int error_total();
        return mon_errors + errors_tb;
    endfunction

    task automatic finish_test(input string name, input int mark);
        tests_run++;
        if (error_total() > mark) begin
            tests_failed++;
            $display("test %s: FAIL, %0d new errors", name, error_total() - mark);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // DUT outputs are read on the falling edge
    task automatic wait_done_level(input logic level, input int limit, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (done !== level && n < limit);
        if (done !== level) begin
            $display("timeout after %0d clocks waiting for %s", n, what);
            errors_tb++;
        end
    endtask

    // monitor counters settle on the falling edge, read them on the rising one
    task automatic wait_counter(input logic frame_cnt, input int count, input int limit,
                                input string what);
        int n;
        n = 0;
        while ((frame_cnt ? mon_frames : mon_starts) < count && n < limit) begin
            @(posedge clk);
            n++;
        end
        if ((frame_cnt ? mon_frames : mon_starts) < count) begin
            $display("timeout after %0d clocks waiting for %s", n, what);
            errors_tb++;
        end
    endtask

    task automatic run_pass(input int pass);
        int   mark;
        int   n;
        logic dropped;
        mark = error_total();
        wait_done_level(1'b1, PASS_LIMIT, "done at the end of the table");
        wait_counter(1'b1, mon_writes, 2 * FRAME_CLKS, "the last frame to finish");
        finish_test($sformatf("pass %0d frames", pass), mark);
        mark = error_total();
        dropped = 1'b0;
        for (n = 0; n < 4 * FRAME_CLKS; n++) begin
            @(negedge clk);
            dropped = dropped | (done !== 1'b1);
        end
        if (dropped) begin
            $display("done dropped without a restart in pass %0d", pass);
            errors_tb++;
        end
        @(posedge clk);
        if (mon_frames != mon_writes) begin
            $display("Mismatch pass %0d frame count: got 0x%h, expected 0x%h",
                     pass, mon_frames, mon_writes);
            errors_tb++;
        end
        finish_test($sformatf("pass %0d completion", pass), mark);
    endtask

    initial begin
        int mark;
        int wait_cycles;
        seed         = 54272;
        reset        = 1'b1;
        restart      = 1'b0;
        errors_tb    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0; // monitor still sees reset on this edge

        mark = error_total();
        wait_counter(1'b0, 1, 8 * PERIOD + 64, "the first start condition");
        finish_test("reset and power-up", mark);

        run_pass(1);

        mark = error_total();
        wait_cycles = $random(seed) & 255;
        repeat (wait_cycles) @(negedge clk);
        restart = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        wait_done_level(1'b0, 16, "done to drop after restart");
        finish_test("restart", mark);

        run_pass(2);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_total());
        if (error_total() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: source/cam_cfg_pkg.sv
// ################################################
// shared types, constants and the OV7670 register table
// used by the camera config sequencer and the bench monitor
// ################################################

package cam_cfg_pkg;

    // one table row, address in the upper byte
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] value;
    } cam_entry_t;

    localparam logic [7:0] CAM_ID_WRITE = 8'h42; // OV7670 write id

    // special addresses, never sent on the bus
    localparam logic [7:0] ADDR_DELAY = 8'hF0; // value = delay units
    localparam logic [7:0] ADDR_END   = 8'hFF; // stops the walk

    localparam int CAM_TABLE_LEN = 24; // includes the end marker

    // sequencer FSM states
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_send,
        st_wait_delay,
        st_done
    } seq_state_t;

    // RGB565 output, internal clock straight through, default window
    localparam cam_entry_t CAM_REG_TABLE [CAM_TABLE_LEN] = '{
        '{8'h12, 8'h80}, // COM7 soft reset
        '{8'hF0, 8'h04}, // wait for the reset to settle

        // format and clock
        '{8'h12, 8'h04}, // COM7 RGB output
        '{8'h11, 8'h80}, // CLKRC no prescale
        '{8'h0C, 8'h00}, // COM3 no scaling
        '{8'h3E, 8'h00}, // COM14 pclk normal
        '{8'h04, 8'h00}, // COM1 no CCIR656
        '{8'h40, 8'hD0}, // COM15 RGB565 full range
        '{8'h3A, 8'h04}, // TSLB output sequence
        '{8'h14, 8'h18}, // COM9 gain ceiling 4x

        // colour matrix
        '{8'h4F, 8'hB3}, // MTX1
        '{8'h50, 8'hB3}, // MTX2
        '{8'h51, 8'h00}, // MTX3
        '{8'h52, 8'h3D}, // MTX4
        '{8'h53, 8'hA7}, // MTX5
        '{8'h54, 8'hE4}, // MTX6
        '{8'h58, 8'h9E}, // MTXS sign bits
        '{8'h3D, 8'hC0}, // COM13 gamma and uv saturation

        // frame window
        '{8'h17, 8'h14}, // HSTART
        '{8'h18, 8'h02}, // HSTOP
        '{8'h32, 8'h80}, // HREF edge offsets
        '{8'h19, 8'h03}, // VSTART
        '{8'h1A, 8'h7B}, // VSTOP

        '{8'hFF, 8'hFF}  // end of table
    };

endpackage

// File: source/cam_cfg_sequencer.sv
// ################################################
// walks the camera register table and feeds the SCCB sender
// restart pulse runs the whole table again
// ################################################
`timescale 1ns/1ps

module cam_cfg_sequencer #(
    parameter int DELAY_UNIT = 25000 // clocks per delay unit
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       restart,
    input  logic       taken,
    output logic       send,
    output logic [7:0] reg_addr,
    output logic [7:0] value,
    output logic       done
);

    import cam_cfg_pkg::*;

    localparam int IDX_W = $clog2(CAM_TABLE_LEN);
    localparam int CNT_W = $clog2(256 * DELAY_UNIT);

    seq_state_t       state;
    logic [IDX_W-1:0] index;
    logic [CNT_W-1:0] delay_cnt;
    logic             restart_pend; // restart seen while a send was open
    logic             restart_req;
    cam_entry_t       entry;

    assign entry       = CAM_REG_TABLE[index];
    assign restart_req = restart | restart_pend;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            index        <= '0;
            delay_cnt    <= '0;
            restart_pend <= 1'b0;
            send         <= 1'b0;
            done         <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    index        <= '0;
                    done         <= 1'b0;
                    restart_pend <= 1'b0;
                    state        <= st_fetch;
                end

                st_fetch: begin
                    if (restart_req) begin
                        state <= st_idle;
                    end else if (entry.addr == ADDR_END) begin
                        done  <= 1'b1;
                        state <= st_done;
                    end else if (entry.addr == ADDR_DELAY) begin
                        delay_cnt <= CNT_W'(entry.value * DELAY_UNIT);
                        state     <= st_wait_delay;
                    end else begin
                        reg_addr <= entry.addr;
                        value    <= entry.value;
                        send     <= 1'b1;
                        state    <= st_send;
                    end
                end

                st_send: begin
                    // keep send up until the sender loads the frame
                    if (restart) begin
                        restart_pend <= 1'b1;
                    end
                    if (taken) begin
                        send  <= 1'b0;
                        index <= index + 1'b1;
                        state <= restart_req ? st_idle : st_fetch;
                    end
                end

                st_wait_delay: begin
                    if (restart_req) begin
                        state <= st_idle;
                    end else if (delay_cnt <= CNT_W'(1)) begin
                        index <= index + 1'b1;
                        state <= st_fetch;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end

                st_done: begin
                    if (restart_req) begin
                        state <= st_idle; // done drops in idle
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: source/cam_cfg_top.sv
// ################################################
// OV7670 config top, sequencer plus SCCB write master
// ################################################
`timescale 1ns/1ps

module cam_cfg_top #(
    parameter int DIV_BITS   = 8,     // bit period 2**DIV_BITS clocks
    parameter int DELAY_UNIT = 25000  // 1 ms at 25 MHz
) (
    input  logic clk,
    input  logic reset,
    input  logic restart,
    output logic done,
    output logic sioc,
    output logic siod_out,
    output logic siod_oe
);

    import cam_cfg_pkg::*;

    logic       send;
    logic       taken;
    logic [7:0] reg_addr;
    logic [7:0] value;

    cam_cfg_sequencer #(
        .DELAY_UNIT (DELAY_UNIT)
    ) i_sequencer (
        .clk      (clk),
        .reset    (reset),
        .restart  (restart),
        .taken    (taken),
        .send     (send),
        .reg_addr (reg_addr),
        .value    (value),
        .done     (done)
    );

    sccb_sender #(
        .DIV_BITS (DIV_BITS)
    ) i_sender (
        .clk      (clk),
        .reset    (reset),
        .send     (send),
        .sccb_id  (CAM_ID_WRITE), // write id, every frame
        .reg_addr (reg_addr),
        .value    (value),
        .taken    (taken),
        .sioc     (sioc),
        .siod_out (siod_out),
        .siod_oe  (siod_oe)
    );

endmodule

// File: source/sccb_sender.sv
// ################################################
// SCCB write master, one 3-phase write per taken pulse
// hold send with stable data until taken is seen
// ################################################
`timescale 1ns/1ps

module sccb_sender #(
    parameter int DIV_BITS = 8 // bit period is 2**DIV_BITS clocks
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       send,
    input  logic [7:0] sccb_id,
    input  logic [7:0] reg_addr,
    input  logic [7:0] value,
    output logic       taken,
    output logic       sioc,
    output logic       siod_out,
    output logic       siod_oe
);

    logic [DIV_BITS-1:0] divider;
    logic [31:0]         busy_sr;  // ones mark the periods still to go
    logic [31:0]         data_sr;  // msb is on the wire
    logic [1:0]          phase;    // quarter of the current bit period
    logic                sioc_next;
    logic                ack_slot;

    assign phase = divider[DIV_BITS-1 -: 2];

    // the 1->0 edge in busy_sr sits at the bit slot being sent,
    // so these three pairs are the 9th bit after each byte
    assign ack_slot = (busy_sr[11:10] == 2'b10) ||
                      (busy_sr[20:19] == 2'b10) ||
                      (busy_sr[29:28] == 2'b10);

    assign siod_out = data_sr[31];
    assign siod_oe  = ~ack_slot; // let the slave drive the ack bit

    // clock level per period, picked from the ends of busy_sr
    always_comb begin
        case ({busy_sr[31:29], busy_sr[2:0]})
            6'b111_111: begin
                sioc_next = 1'b1; // line still high
            end
            6'b111_110: begin
                sioc_next = 1'b1; // siod falls here, start
            end
            6'b111_100: begin
                sioc_next = 1'b0; // clock down before the first bit
            end
            6'b110_000: begin
                sioc_next = (phase != 2'b00); // clock up, line low
            end
            6'b100_000: begin
                sioc_next = 1'b1; // siod rises here, stop
            end
            6'b000_000: begin
                sioc_next = 1'b1; // idle
            end
            default: begin
                // data bit: low, high, high, low
                sioc_next = (phase == 2'b01) || (phase == 2'b10);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            divider <= DIV_BITS'(1); // power-up pause before first frame
            busy_sr <= '0;
            data_sr <= '1;
            taken   <= 1'b0;
            sioc    <= 1'b1;
        end else begin
            taken <= 1'b0;
            sioc  <= sioc_next;

            if (!busy_sr[31]) begin
                if (send) begin
                    if (divider == '0) begin
                        // 3 start periods, 27 bits, 2 stop periods
                        data_sr <= {3'b100, sccb_id, 1'b0, reg_addr, 1'b0,
                                    value, 1'b0, 2'b01};
                        busy_sr <= '1;
                        taken   <= 1'b1;
                    end else begin
                        divider <= divider + 1'b1; // only after reset
                    end
                end
            end else begin
                if (divider == '1) begin
                    busy_sr <= {busy_sr[30:0], 1'b0};
                    data_sr <= {data_sr[30:0], 1'b1}; // idle fill is high
                    divider <= '0;
                end else begin
                    divider <= divider + 1'b1;
                end
            end
        end
    end

endmodule

// File: src.f
source/cam_cfg_pkg.sv
source/sccb_sender.sv
source/cam_cfg_sequencer.sv
source/cam_cfg_top.sv
bench/sccb_monitor.sv
bench/tb_cam_cfg.sv
